//--- verilog.f
rtl/axil_bus_pkg.sv
rtl/fetch_pkg.sv
rtl/fetch_requester.sv
rtl/flush_tracker.sv
rtl/fetch_word_fifo.sv
rtl/insn_unpacker.sv
rtl/axil_fetch.sv
tests/tb_axil_fetch.sv

//--- run.sh
#!/bin/sh
# Build and run the prefetch testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal \
	--top-module tb_axil_fetch \
	-f verilog.f \
	-o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "Simulation completed successfully" sim.log; then
	exit 0
else
	exit 1
fi

//--- tests/tb_axil_fetch.sv
// Prefetch unit testbench

module tb_axil_fetch;

	// About four times the expected stimulus length
	localparam int TIMEOUT_CYCLES = 3000;
	localparam logic [31:0] INSN_KEY = 32'h5a5a_0000;

	logic                  clk;
	logic                  aresetn;
	fetch_pkg::cpu_cmd_t   cmd;
	logic                  i_ready;
	fetch_pkg::fetch_out_t out;
	axil_bus_pkg::ar_req_t ar;
	logic                  arready;
	axil_bus_pkg::r_resp_t r_in;
	logic                  rready;

	integer seed;
	int     cycles, errors, tests_run, tests_failed, test_err_base;
	// CPU model knobs
	logic   ready_en;
	int     ready_pct;
	// Reference model state
	logic [31:0] exp_pc;
	logic        exp_illegal;
	int          accept_count, illegal_accepts, hold_checks, ctrl_checks;
	// Back-pressure snapshot
	logic                  hold_armed;
	fetch_pkg::fetch_out_t held;
	// Post clear or reset check
	logic ctrl_armed, ctrl_ar_free;
	// Memory slave queues in request order
	logic [31:0] addr_q [$];
	int          due_q [$];
	int          slave_cycle, last_due;

	axil_fetch #(
		.FETCH_LIMIT(8)
	) uut (
		.S_AXI_ACLK   (clk),
		.S_AXI_ARESETN(aresetn),
		.i_cmd        (cmd),
		.i_ready      (i_ready),
		.o_out        (out),
		.o_ar         (ar),
		.i_arready    (arready),
		.i_r          (r_in),
		.o_rready     (rready)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	////////////////////////////////////////////////////////////////////////////
	// Model helpers
	////////////////////////////////////////////////////////////////////////////

	// Instruction contents for a byte address
	function automatic logic [31:0] insn_at(input logic [31:0] a);
		return a ^ INSN_KEY;
	endfunction

	function automatic logic in_error_window(input logic [31:0] a);
		logic [31:0] w;
		w = a & ~32'h7;
		return (w >= 32'h800) && (w <= 32'h80f);
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] e, input logic [31:0] a);
		$display("CHECK FAILED at %0t: %s expected %h actual %h", $time, name, e, a);
		errors++;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Memory slave, CPU ready and timeout
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clk)
	begin : mem_slave
		int          due;
		logic [31:0] w;
		slave_cycle++;
		if (!aresetn)
		begin
			addr_q.delete();
			due_q.delete();
			arready  <= 1'b0;
			r_in     <= '0;
		end
		else
		begin
			// AR transfer on this edge
			if (ar.arvalid && arready)
			begin
				due = slave_cycle + 1 + ($unsigned($random(seed)) % 4);
				if (due <= last_due)
					due = last_due + 1;
				last_due = due;
				addr_q.push_back(ar.araddr);
				due_q.push_back(due);
			end
			arready <= ($unsigned($random(seed)) % 100) < 70;
			if (due_q.size() > 0 && due_q[0] <= slave_cycle)
			begin
				w = addr_q.pop_front() & ~32'h7;
				void'(due_q.pop_front());
				r_in.rvalid <= 1'b1;
				r_in.rdata  <= {insn_at(w + 32'h4), insn_at(w)};
				r_in.rresp  <= in_error_window(w) ? 2'd2 : 2'd0;
			end
			else
				r_in.rvalid <= 1'b0;
		end
	end

	always @(posedge clk)
	begin
		if (!aresetn)
			i_ready <= 1'b0;
		else
			i_ready <= ready_en && (($unsigned($random(seed)) % 100) < ready_pct);
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Simulation failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Monitor on the falling edge
	////////////////////////////////////////////////////////////////////////////

	always @(negedge clk)
	begin : monitor
		logic restart;
		restart = cmd.cpu_reset || cmd.new_pc || cmd.clear_cache;
		if (aresetn)
		begin
			// Returns are never back-pressured
			if (rready !== 1'b1)
				report_mismatch("o_rready", 1, rready);
			// Outputs frozen under a stall
			if (hold_armed)
			begin
				hold_checks++;
				if (out.valid !== 1'b1)
					report_mismatch("o_out.valid (held)", 1, out.valid);
				if (out.insn !== held.insn)
					report_mismatch("o_out.insn (held)", held.insn, out.insn);
				if (out.pc !== held.pc)
					report_mismatch("o_out.pc (held)", held.pc, out.pc);
				if (out.illegal !== held.illegal)
					report_mismatch("o_out.illegal (held)", held.illegal, out.illegal);
			end
			hold_armed = out.valid && !i_ready && !restart;
			held       = out;
			// Cycle after clear_cache or cpu_reset
			if (ctrl_armed)
			begin
				ctrl_checks++;
				if (out.valid !== 1'b0)
					report_mismatch("o_out.valid", 0, out.valid);
				if (ctrl_ar_free && ar.arvalid !== 1'b0)
					report_mismatch("o_ar.arvalid", 0, ar.arvalid);
			end
			ctrl_armed   = (cmd.clear_cache || cmd.cpu_reset) && !cmd.new_pc;
			ctrl_ar_free = !ar.arvalid || arready;
			// Accepted instruction against the model
			if (!restart && out.valid && i_ready)
			begin
				if (!exp_illegal && in_error_window(exp_pc))
					exp_illegal = 1'b1;
				if (out.illegal !== exp_illegal)
					report_mismatch("o_out.illegal", exp_illegal, out.illegal);
				if (out.pc !== exp_pc)
					report_mismatch("o_out.pc", exp_pc, out.pc);
				if (!exp_illegal && out.insn !== insn_at(exp_pc))
					report_mismatch("o_out.insn", insn_at(exp_pc), out.insn);
				// pc freezes on a bus error
				if (!exp_illegal)
					exp_pc = exp_pc + 32'h4;
				else
					illegal_accepts++;
				accept_count++;
			end
			if (cmd.new_pc)
			begin
				exp_pc      = cmd.pc;
				exp_illegal = 1'b0;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic redirect(input logic [31:0] target);
		@(posedge clk);
		cmd.new_pc <= 1'b1;
		cmd.pc     <= target;
		ready_en   <= 1'b1;
		@(posedge clk);
		cmd.new_pc <= 1'b0;
	endtask

	// One cycle of clear_cache or cpu_reset with the CPU stalled
	task automatic pulse_control(input logic is_reset);
		@(posedge clk);
		ready_en <= 1'b0;
		if (is_reset)
			cmd.cpu_reset <= 1'b1;
		else
			cmd.clear_cache <= 1'b1;
		@(posedge clk);
		cmd.cpu_reset   <= 1'b0;
		cmd.clear_cache <= 1'b0;
	endtask

	task automatic wait_accepts(input int n);
		int target;
		target = accept_count + n;
		while (accept_count < target)
			@(posedge clk);
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge clk);
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (errors != test_err_base)
			tests_failed++;
		$display("%s: %s (%0d errors)", name,
			(errors == test_err_base) ? "passed" : "failed", errors - test_err_base);
		test_err_base = errors;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		int base;
		seed = 32'h24ea_1ad0;
		aresetn = 1'b0;
		cmd = '0;
		cmd.cpu_reset = 1'b1;
		i_ready = 1'b0;
		r_in = '0;
		arready = 1'b0;
		ready_en = 1'b0;
		ready_pct = 60;
		exp_pc = '0;
		exp_illegal = 1'b0;
		hold_armed = 1'b0;
		ctrl_armed = 1'b0;
		ctrl_ar_free = 1'b0;
		last_due = 0;
		repeat (5) @(posedge clk);

		// Leave reset straight into the first redirect
		aresetn       <= 1'b1;
		cmd.cpu_reset <= 1'b0;
		cmd.new_pc    <= 1'b1;
		cmd.pc        <= 32'h100;
		ready_en      <= 1'b1;
		@(posedge clk);
		cmd.new_pc <= 1'b0;
		wait_accepts(200);
		finish_test("sequential stream");

		for (int i = 0; i < 8; i++)
		begin
			wait_accepts($unsigned($random(seed)) % 24);
			idle_cycles($unsigned($random(seed)) % 6);
			redirect((i == 2) ? 32'h204 : (($unsigned($random(seed)) % 256) * 4));
		end
		wait_accepts(20);
		finish_test("redirect mid-stream");

		base = hold_checks;
		ready_pct <= 20;
		redirect(32'h600);
		wait_accepts(40);
		ready_pct <= 60;
		if (hold_checks == base)
		begin
			$display("Back-pressure test never saw a stalled valid output");
			errors++;
		end
		finish_test("CPU back-pressure");

		base = illegal_accepts;
		redirect(32'h7f8);
		while (illegal_accepts < base + 4)
			@(posedge clk);
		redirect(32'h100);
		wait_accepts(4);
		finish_test("bus error");

		base = ctrl_checks;
		pulse_control(1'b0);
		idle_cycles(6);
		redirect(32'h300);
		wait_accepts(10);
		pulse_control(1'b1);
		idle_cycles(6);
		redirect(32'h340);
		wait_accepts(10);
		@(posedge clk);
		ready_en      <= 1'b0;
		aresetn       <= 1'b0;
		cmd.cpu_reset <= 1'b1;
		repeat (5) @(posedge clk);
		@(negedge clk);
		if (out.valid !== 1'b0)
			report_mismatch("o_out.valid (reset)", 0, out.valid);
		if (ar.arvalid !== 1'b0)
			report_mismatch("o_ar.arvalid (reset)", 0, ar.arvalid);
		if (out.illegal !== 1'b0)
			report_mismatch("o_out.illegal (reset)", 0, out.illegal);
		if (ctrl_checks != base + 2)
		begin
			$display("Clear cache and CPU reset were not both observed");
			errors++;
		end
		finish_test("clear cache and reset");

		$display("Tests run %0d, failed %0d, accepts %0d, errors %0d",
			tests_run, tests_failed, accept_count, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- rtl/axil_fetch.sv
// AXI-lite instruction prefetch

module axil_fetch #(
	parameter int FETCH_LIMIT = 16
) (
	input  logic                  S_AXI_ACLK,
	input  logic                  S_AXI_ARESETN,
	// CPU side
	input  fetch_pkg::cpu_cmd_t   i_cmd,
	input  logic                  i_ready,
	output fetch_pkg::fetch_out_t o_out,
	// Bus side
	output axil_bus_pkg::ar_req_t o_ar,
	input  logic                  i_arready,
	input  axil_bus_pkg::r_resp_t i_r,
	output logic                  o_rready
);

	// Restart decoded once, shared by every stage
	logic                   restart;
	// Flush bookkeeping
	logic                   bus_full;
	logic                   flushing;
	logic                   flush_request;
	// Unpacker feedback for the throttle
	logic                   word_taken;
	logic                   out_held;
	// FIFO read side
	logic                   fifo_rd;
	logic                   fifo_empty;
	fetch_pkg::fetch_word_t fifo_word;

	// Returns are never stalled
	assign o_rready = 1'b1;

	////////////////////////////////////////////////////////////////////////////
	// Request, flush, buffer, unpack
	////////////////////////////////////////////////////////////////////////////

	fetch_requester #(
		.FETCH_LIMIT(FETCH_LIMIT)
	) u_requester (
		.S_AXI_ACLK     (S_AXI_ACLK),
		.S_AXI_ARESETN  (S_AXI_ARESETN),
		.i_cmd          (i_cmd),
		.i_arready      (i_arready),
		.i_bus_full     (bus_full),
		.i_flush_request(flush_request),
		.i_word_taken   (word_taken),
		.i_out_held     (out_held),
		.o_ar           (o_ar),
		.o_restart      (restart)
	);

	flush_tracker #(
		.FETCH_LIMIT(FETCH_LIMIT)
	) u_flush (
		.S_AXI_ACLK     (S_AXI_ACLK),
		.S_AXI_ARESETN  (S_AXI_ARESETN),
		.i_restart      (restart),
		.i_ar           (o_ar),
		.i_arready      (i_arready),
		.i_rvalid       (i_r.rvalid),
		.o_bus_full     (bus_full),
		.o_flushing     (flushing),
		.o_flush_request(flush_request)
	);

	fetch_word_fifo #(
		.FETCH_LIMIT(FETCH_LIMIT)
	) u_fifo (
		.S_AXI_ACLK(S_AXI_ACLK),
		.i_restart (restart),
		.i_r       (i_r),
		.i_flushing(flushing),
		.i_rd      (fifo_rd),
		.o_word    (fifo_word),
		.o_empty   (fifo_empty)
	);

	insn_unpacker u_unpacker (
		.S_AXI_ACLK  (S_AXI_ACLK),
		.i_cmd       (i_cmd),
		.i_restart   (restart),
		.i_ready     (i_ready),
		.i_word      (fifo_word),
		.i_empty     (fifo_empty),
		.o_rd        (fifo_rd),
		.o_word_taken(word_taken),
		.o_out_held  (out_held),
		.o_out       (o_out)
	);

endmodule

//--- rtl/insn_unpacker.sv
// Bus word to instruction unpacker

module insn_unpacker (
	input  logic                   S_AXI_ACLK,
	input  fetch_pkg::cpu_cmd_t    i_cmd,
	input  logic                   i_restart,
	input  logic                   i_ready,
	input  fetch_pkg::fetch_word_t i_word,
	input  logic                   i_empty,
	output logic                   o_rd,
	output logic                   o_word_taken,
	output logic                   o_out_held,
	output fetch_pkg::fetch_out_t  o_out
);

	localparam int FILL_W = $clog2(fetch_pkg::INSNS_PER_WORD) + 1;
	localparam int IW     = $bits(fetch_pkg::insn_t);
	localparam int AW     = $bits(axil_bus_pkg::axi_addr_t);
	localparam int BLSB   = axil_bus_pkg::BUS_LSB;
	localparam int ILSB   = fetch_pkg::INSN_LSB;
	localparam logic [FILL_W-1:0] FULL_FILL = FILL_W'(fetch_pkg::INSNS_PER_WORD);

	logic                    valid_q;
	logic                    illegal_q;
	axil_bus_pkg::axi_addr_t pc_q;
	// Current word, next instruction in the low bits
	axil_bus_pkg::axi_data_t out_data;
	// Instructions left in out_data
	logic [FILL_W-1:0]       out_fill;
	// Instruction slot of pc within its bus word
	logic [BLSB-ILSB-1:0]    shift;
	logic                    accept;

	assign accept = valid_q && i_ready;
	assign shift  = pc_q[BLSB-1:ILSB];

	// Pull a word when idle or on the last slot
	assign o_rd         = !valid_q || (i_ready && (out_fill <= FILL_W'(1)));
	assign o_word_taken = o_rd && !i_empty;
	// Output word still here next cycle
	assign o_out_held   = valid_q && (!i_ready || (out_fill > FILL_W'(1)));

	////////////////////////////////////////////////////////////////////////////
	// Output handshake
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_restart)
			valid_q <= 1'b0;
		else if (!valid_q || i_ready)
			valid_q <= o_word_taken || (out_fill > (valid_q ? FILL_W'(1) : FILL_W'(0)));
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_restart)
			out_fill <= '0;
		else if (o_rd)
		begin
			if (i_empty)
				out_fill <= '0;
			else if (valid_q)
				out_fill <= FULL_FILL;
			else
				// First word of a stream may start mid-word
				out_fill <= FULL_FILL - FILL_W'(shift);
		end
		else if (i_ready && (out_fill != '0))
			out_fill <= out_fill - 1'b1;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (o_rd)
		begin
			if (valid_q)
				out_data <= i_word.data;
			else
				// Drop the slots below pc
				out_data <= i_word.data >> (IW * int'(shift));
		end
		else if (i_ready)
			out_data <= out_data >> IW;
	end

	////////////////////////////////////////////////////////////////////////////
	// PC and error flag
	////////////////////////////////////////////////////////////////////////////

	// pc freezes once a bus error shows up
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_cmd.new_pc)
			pc_q <= i_cmd.pc;
		else if (accept && !illegal_q)
			pc_q <= {pc_q[AW-1:ILSB] + 1'b1, {(ILSB){1'b0}}};
	end

	// Sticky until the next restart
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_restart)
			illegal_q <= 1'b0;
		else if (!illegal_q && o_word_taken)
			illegal_q <= i_word.illegal;
	end

	assign o_out.valid   = valid_q;
	assign o_out.illegal = illegal_q;
	assign o_out.pc      = pc_q;
	assign o_out.insn    = out_data[IW-1:0];

endmodule

//--- rtl/fetch_word_fifo.sv
// Returned bus word FIFO

module fetch_word_fifo #(
	parameter int FETCH_LIMIT = 16
) (
	input  logic                   S_AXI_ACLK,
	input  logic                   i_restart,
	input  axil_bus_pkg::r_resp_t  i_r,
	input  logic                   i_flushing,
	input  logic                   i_rd,
	output fetch_pkg::fetch_word_t o_word,
	output logic                   o_empty
);

	localparam int LGFIFO = $clog2(FETCH_LIMIT);

	// Circular storage
	fetch_pkg::fetch_word_t mem [FETCH_LIMIT];
	// One extra bit separates full from empty
	logic [LGFIFO:0]        wr_ptr;
	logic [LGFIFO:0]        rd_ptr;
	logic                   wr;
	logic                   rd;

	// Stale returns are dropped, including one on the restart cycle
	assign wr = i_r.rvalid && !i_flushing && !i_restart;
	assign rd = i_rd && !o_empty;

	////////////////////////////////////////////////////////////////////////////
	// Pointers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_restart)
		begin
			// Buffered words belong to the old stream
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Storage
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (wr)
		begin
			// RRESP bit 1 marks a bus error
			mem[wr_ptr[LGFIFO-1:0]].illegal <= i_r.rresp[1];
			mem[wr_ptr[LGFIFO-1:0]].data    <= i_r.rdata;
		end
	end

	assign o_empty = (wr_ptr == rd_ptr);

	// Head of queue, visible the cycle after its write
	assign o_word = mem[rd_ptr[LGFIFO-1:0]];

endmodule

//--- rtl/flush_tracker.sv
// Outstanding read and flush tracker

module flush_tracker #(
	parameter int FETCH_LIMIT = 16
) (
	input  logic                  S_AXI_ACLK,
	input  logic                  S_AXI_ARESETN,
	input  logic                  i_restart,
	input  axil_bus_pkg::ar_req_t i_ar,
	input  logic                  i_arready,
	input  logic                  i_rvalid,
	output logic                  o_bus_full,
	output logic                  o_flushing,
	output logic                  o_flush_request
);

	localparam int LGDEPTH = $clog2(FETCH_LIMIT) + 4;
	localparam int CNT_W   = LGDEPTH + 1;
	// Outstanding reads cap
	localparam logic [CNT_W-1:0] CAP = CNT_W'((1 << LGDEPTH) - 1);

	logic [CNT_W-1:0] outstanding;
	logic [CNT_W-1:0] next_outstanding;
	// Returns still to be thrown away
	logic [CNT_W-1:0] flushcount;
	logic [CNT_W-1:0] new_flushcount;
	logic             ar_xfer;

	assign ar_xfer = i_ar.arvalid && i_arready;

	always_comb
	begin
		next_outstanding = outstanding;
		case ({ar_xfer, i_rvalid})
			2'b10:   next_outstanding = outstanding + 1'b1;
			2'b01:   next_outstanding = outstanding - 1'b1;
			default: next_outstanding = outstanding;
		endcase
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			outstanding <= '0;
			o_bus_full  <= 1'b0;
		end
		else
		begin
			outstanding <= next_outstanding;
			o_bus_full  <= (next_outstanding >= CAP);
		end
	end

	// Everything in flight is stale, a waiting AR too
	// The return on this cycle is dropped at the FIFO already
	assign new_flushcount = outstanding + CNT_W'(i_ar.arvalid) - CNT_W'(i_rvalid);

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			flushcount      <= '0;
			o_flushing      <= 1'b0;
			o_flush_request <= 1'b0;
		end
		else if (i_restart)
		begin
			flushcount      <= new_flushcount;
			o_flushing      <= (new_flushcount != '0);
			// Stale AR still parked on the channel
			o_flush_request <= i_ar.arvalid && !i_arready;
		end
		else
		begin
			if (i_rvalid && (flushcount != '0))
			begin
				flushcount <= flushcount - 1'b1;
				o_flushing <= (flushcount > CNT_W'(1));
			end
			if (i_arready)
				o_flush_request <= 1'b0;
		end
	end

endmodule

//--- rtl/fetch_requester.sv
// Fetch address requester

module fetch_requester #(
	parameter int FETCH_LIMIT = 16
) (
	input  logic                  S_AXI_ACLK,
	input  logic                  S_AXI_ARESETN,
	input  fetch_pkg::cpu_cmd_t   i_cmd,
	input  logic                  i_arready,
	input  logic                  i_bus_full,
	input  logic                  i_flush_request,
	input  logic                  i_word_taken,
	input  logic                  i_out_held,
	output axil_bus_pkg::ar_req_t o_ar,
	output logic                  o_restart
);

	// Fill never exceeds FETCH_LIMIT
	localparam int FILL_W = $clog2(FETCH_LIMIT) + 1;
	// Room for fill plus two single-bit terms
	localparam int SUM_W  = FILL_W + 1;
	localparam int AW     = $bits(axil_bus_pkg::axi_addr_t);
	localparam int LSB    = axil_bus_pkg::BUS_LSB;

	logic                    arvalid_q;
	axil_bus_pkg::axi_addr_t araddr_q;
	// New PC seen while an AR was stalled
	logic                    pending_new_pc;
	axil_bus_pkg::axi_addr_t pending_pc;
	// Words requested and not yet pulled from the FIFO
	logic [FILL_W-1:0]       fill;
	logic [SUM_W-1:0]        throttle_sum;
	logic                    throttled;
	logic                    ar_free;
	logic                    ar_xfer;

	// Any of the three CPU controls restarts the stream
	assign o_restart = i_cmd.cpu_reset || i_cmd.new_pc || i_cmd.clear_cache;

	// AR slot can take a new request
	assign ar_free = !arvalid_q || i_arready;
	assign ar_xfer = arvalid_q && i_arready;

	// Words in flight, buffered and held at the output
	assign throttle_sum = SUM_W'(fill) + SUM_W'(arvalid_q) + SUM_W'(i_out_held);
	assign throttled    = (throttle_sum >= SUM_W'(FETCH_LIMIT));

	////////////////////////////////////////////////////////////////////////////
	// AR channel
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			arvalid_q <= 1'b0;
		else if (ar_free)
		begin
			// Default is to keep fetching
			arvalid_q <= 1'b1;
			if (throttled)
				arvalid_q <= 1'b0;
			// Hard stops win over everything
			if (i_cmd.cpu_reset || i_cmd.clear_cache || i_bus_full)
				arvalid_q <= 1'b0;
		end
	end

	// Address only moves once the slot is free
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (ar_free)
		begin
			if (i_cmd.new_pc)
				araddr_q <= i_cmd.pc;
			else if (pending_new_pc)
				araddr_q <= pending_pc;
			else if (arvalid_q)
				// Next bus word, aligned
				araddr_q <= {araddr_q[AW-1:LSB] + 1'b1, {(LSB){1'b0}}};
		end
	end

	assign o_ar.arvalid = arvalid_q;
	assign o_ar.araddr  = araddr_q;

	////////////////////////////////////////////////////////////////////////////
	// Pending redirect
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_cmd.clear_cache)
			pending_new_pc <= 1'b0;
		else if (ar_free)
			pending_new_pc <= 1'b0;
		else if (i_cmd.new_pc)
			pending_new_pc <= 1'b1;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_cmd.new_pc)
			pending_pc <= i_cmd.pc;
	end

	// Fill count, stale AR from before a restart is not counted
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || o_restart)
			fill <= '0;
		else
		begin
			case ({ar_xfer && !i_flush_request, i_word_taken})
				2'b10:   fill <= fill + 1'b1;
				2'b01:   fill <= fill - 1'b1;
				default: fill <= fill;
			endcase
		end
	end

endmodule

//--- rtl/fetch_pkg.sv
// CPU fetch interface types

package fetch_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Instruction geometry
	////////////////////////////////////////////////////////////////////////////

	// One instruction as seen by the CPU
	typedef logic [31:0] insn_t;

	// Byte offset bits within an instruction
	localparam int INSN_LSB = 2;

	// Instructions packed in one bus word
	localparam int INSNS_PER_WORD = 2;

	////////////////////////////////////////////////////////////////////////////
	// Bundles
	////////////////////////////////////////////////////////////////////////////

	// FIFO entry, bus word plus its error flag
	typedef struct packed {
		logic                  illegal;
		axil_bus_pkg::axi_data_t data;
	} fetch_word_t;

	// Control from the CPU
	// pc is only looked at with new_pc
	typedef struct packed {
		logic                  cpu_reset;
		logic                  new_pc;
		logic                  clear_cache;
		axil_bus_pkg::axi_addr_t pc;
	} cpu_cmd_t;

	// Instruction stream back to the CPU
	typedef struct packed {
		logic                  valid;
		logic                  illegal;
		axil_bus_pkg::axi_addr_t pc;
		insn_t                 insn;
	} fetch_out_t;

endpackage

//--- rtl/axil_bus_pkg.sv
// AXI-lite read channel types

package axil_bus_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Bus geometry
	////////////////////////////////////////////////////////////////////////////

	// Byte address on the read address channel
	typedef logic [31:0] axi_addr_t;

	// One full bus data word
	typedef logic [63:0] axi_data_t;

	// Byte offset bits within a bus word
	localparam int BUS_LSB = 3;

	////////////////////////////////////////////////////////////////////////////
	// Channel bundles
	////////////////////////////////////////////////////////////////////////////

	// AR channel, driven by the fetch unit
	typedef struct packed {
		logic      arvalid;
		axi_addr_t araddr;
	} ar_req_t;

	// R channel, returned by memory
	// RRESP bit 1 flags SLVERR or DECERR
	typedef struct packed {
		logic       rvalid;
		axi_data_t  rdata;
		logic [1:0] rresp;
	} r_resp_t;

endpackage
